// ==== issue_queue.f ====
+incdir+logic
logic/isq_pkg.sv
logic/isq_entries.sv
logic/preg_ready_table.sv
logic/issue_select.sv
logic/issue_queue.sv
tb/issue_queue_sva.sv
tb/tb_issue_queue.sv

// ==== logic/isq_defs.svh ====
`ifndef ISQ_DEFS_SVH
`define ISQ_DEFS_SVH

////////////////////////////////////////////////////////////
// issue queue geometry
////////////////////////////////////////////////////////////

// number of slots in the queue
`define ISQ_DEPTH 8
// slot index width, log2 of the depth
`define ISQ_IDX_BITS 3

////////////////////////////////////////////////////////////
// physical register file
////////////////////////////////////////////////////////////

`define PREG_NUM 64
`define PREG_BITS 6
// register to free at retire, msb is its valid flag
`define FREE_PREG_BITS 7

////////////////////////////////////////////////////////////
// function unit positions in the ready vector
////////////////////////////////////////////////////////////

`define FU_MULT_BIT 0
`define FU_ALU1_BIT 1
`define FU_ALU2_BIT 2
`define FU_ADDR_BIT 3

`endif

// ==== logic/isq_entries.sv ====
`timescale 1ns/1ps
`include "isq_defs.svh"

module isq_entries (
   input  logic                  clk_i,
   input  logic                  rst_i,
   // one renamed instruction per cycle
   input  logic                  disp_vld_i,
   input  isq_pkg::op_class_e    disp_op_i,
   input  isq_pkg::preg_t        disp_psrc1_i,
   input  isq_pkg::preg_t        disp_psrc2_i,
   input  isq_pkg::preg_t        disp_pdest_i,
   input  isq_pkg::free_preg_t   disp_free_preg_i,
   // slots issued this cycle
   input  logic [`ISQ_DEPTH-1:0] clr_mask_i,
   // slot array as seen by the selector and ready table
   output logic [`ISQ_DEPTH-1:0] slot_vld_o,
   output isq_pkg::op_class_e    slot_op_o [`ISQ_DEPTH],
   output isq_pkg::preg_t        slot_psrc1_o [`ISQ_DEPTH],
   output isq_pkg::preg_t        slot_psrc2_o [`ISQ_DEPTH],
   output isq_pkg::preg_t        slot_pdest_o [`ISQ_DEPTH],
   output isq_pkg::free_preg_t   slot_free_preg_o [`ISQ_DEPTH],
   output logic                  full_o
);

   import isq_pkg::*;

   // lowest free slot, index and one-hot form
   slot_idx_t              free_idx;
   logic [`ISQ_DEPTH-1:0]  free_oh;
   logic                   free_any;
   // dispatch accepted this cycle
   logic                   disp_we;

   ////////////////////////////////////////////////////////////
   // free slot priority encoder
   ////////////////////////////////////////////////////////////

   // scan from the top so the lowest free slot is the last hit
   always_comb
   begin
      free_idx = '0;
      free_oh  = '0;
      free_any = 1'b0;
      for (int s = `ISQ_DEPTH-1; s >= 0; s--)
      begin
         if (!slot_vld_o[s])
         begin
            free_idx    = slot_idx_t'(s);
            free_oh     = '0;
            free_oh[s]  = 1'b1;
            free_any    = 1'b1;
         end
      end
   end

   // full when every slot holds a waiting instruction
   assign full_o = ~free_any;
   // a dispatch against a full queue is dropped
   assign disp_we = disp_vld_i & free_any;

   ////////////////////////////////////////////////////////////
   // valid bits
   ////////////////////////////////////////////////////////////

   // valid doubles as the wait bit, every issue frees its slot
   // set and clear never hit the same slot, set only targets free ones
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         slot_vld_o <= '0;
      else
         slot_vld_o <= (slot_vld_o & ~clr_mask_i) | (free_oh & {`ISQ_DEPTH{disp_we}});
   end

   ////////////////////////////////////////////////////////////
   // payload
   ////////////////////////////////////////////////////////////

   // fields are only looked at while the slot is valid
   always_ff @(posedge clk_i)
   begin
      if (disp_we)
      begin
         slot_op_o[free_idx]        <= disp_op_i;
         slot_psrc1_o[free_idx]     <= disp_psrc1_i;
         slot_psrc2_o[free_idx]     <= disp_psrc2_i;
         slot_pdest_o[free_idx]     <= disp_pdest_i;
         slot_free_preg_o[free_idx] <= disp_free_preg_i;
      end
   end

endmodule

// ==== logic/isq_pkg.sv ====
`include "isq_defs.svh"

package isq_pkg;

   ////////////////////////////////////////////////////////////
   // operation class
   ////////////////////////////////////////////////////////////

   // decides which function unit may take the instruction
   // brjmp covers branches and jumps, both run on alu 1
   typedef enum logic [1:0]
   {
      OP_MULT  = 2'd0,
      OP_ADD   = 2'd1,
      OP_BRJMP = 2'd2,
      OP_ADDR  = 2'd3
   } op_class_e;

   ////////////////////////////////////////////////////////////
   // slot field types
   ////////////////////////////////////////////////////////////

   // position of an instruction in the queue
   typedef logic [`ISQ_IDX_BITS-1:0] slot_idx_t;

   // physical register number, used for psrc1, psrc2 and pdest
   typedef logic [`PREG_BITS-1:0] preg_t;

   // register released when the instruction retires
   // top bit set means the field carries a register
   typedef logic [`FREE_PREG_BITS-1:0] free_preg_t;

endpackage

// ==== logic/issue_queue.sv ====
`timescale 1ns/1ps
`include "isq_defs.svh"

module issue_queue (
   input  logic                  clk_i,
   input  logic                  rst_i,
   // dispatch
   input  logic                  disp_vld_i,
   input  isq_pkg::op_class_e    disp_op_i,
   input  isq_pkg::preg_t        disp_psrc1_i,
   input  isq_pkg::preg_t        disp_psrc2_i,
   input  isq_pkg::preg_t        disp_pdest_i,
   input  isq_pkg::free_preg_t   disp_free_preg_i,
   output logic                  disp_full_o,
   // writeback and unit status
   input  logic                  wb_vld_i,
   input  isq_pkg::preg_t        wb_preg_i,
   input  logic [3:0]            fu_rdy_i,
   // multiplier port
   output logic                  mul_vld_o,
   output isq_pkg::slot_idx_t    mul_idx_o,
   output isq_pkg::preg_t        mul_psrc1_o,
   output isq_pkg::preg_t        mul_psrc2_o,
   output isq_pkg::preg_t        mul_pdest_o,
   output isq_pkg::free_preg_t   mul_free_preg_o,
   // alu 1 port
   output logic                  alu1_vld_o,
   output isq_pkg::slot_idx_t    alu1_idx_o,
   output isq_pkg::preg_t        alu1_psrc1_o,
   output isq_pkg::preg_t        alu1_psrc2_o,
   output isq_pkg::preg_t        alu1_pdest_o,
   output isq_pkg::free_preg_t   alu1_free_preg_o,
   // alu 2 port
   output logic                  alu2_vld_o,
   output isq_pkg::slot_idx_t    alu2_idx_o,
   output isq_pkg::preg_t        alu2_psrc1_o,
   output isq_pkg::preg_t        alu2_psrc2_o,
   output isq_pkg::preg_t        alu2_pdest_o,
   output isq_pkg::free_preg_t   alu2_free_preg_o,
   // address adder port
   output logic                  adr_vld_o,
   output isq_pkg::slot_idx_t    adr_idx_o,
   output isq_pkg::preg_t        adr_psrc1_o,
   output isq_pkg::preg_t        adr_psrc2_o,
   output isq_pkg::preg_t        adr_pdest_o,
   output isq_pkg::free_preg_t   adr_free_preg_o
);

   import isq_pkg::*;

   // slot array between store, ready table and selector
   logic [`ISQ_DEPTH-1:0]  slot_vld;
   op_class_e              slot_op [`ISQ_DEPTH];
   preg_t                  slot_psrc1 [`ISQ_DEPTH];
   preg_t                  slot_psrc2 [`ISQ_DEPTH];
   preg_t                  slot_pdest [`ISQ_DEPTH];
   free_preg_t             slot_free_preg [`ISQ_DEPTH];
   logic [`ISQ_DEPTH-1:0]  slot_src_rdy;
   logic [`ISQ_DEPTH-1:0]  clr_mask;

   ////////////////////////////////////////////////////////////
   // slot store
   ////////////////////////////////////////////////////////////

   isq_entries u_entries (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .disp_vld_i       (disp_vld_i),
      .disp_op_i        (disp_op_i),
      .disp_psrc1_i     (disp_psrc1_i),
      .disp_psrc2_i     (disp_psrc2_i),
      .disp_pdest_i     (disp_pdest_i),
      .disp_free_preg_i (disp_free_preg_i),
      .clr_mask_i       (clr_mask),
      .slot_vld_o       (slot_vld),
      .slot_op_o        (slot_op),
      .slot_psrc1_o     (slot_psrc1),
      .slot_psrc2_o     (slot_psrc2),
      .slot_pdest_o     (slot_pdest),
      .slot_free_preg_o (slot_free_preg),
      .full_o           (disp_full_o)
   );

   ////////////////////////////////////////////////////////////
   // register ready table
   ////////////////////////////////////////////////////////////

   // rename never dispatches into a full queue
   preg_ready_table u_ready (
      .clk_i          (clk_i),
      .rst_i          (rst_i),
      .disp_vld_i     (disp_vld_i),
      .disp_pdest_i   (disp_pdest_i),
      .wb_vld_i       (wb_vld_i),
      .wb_preg_i      (wb_preg_i),
      .slot_psrc1_i   (slot_psrc1),
      .slot_psrc2_i   (slot_psrc2),
      .slot_src_rdy_o (slot_src_rdy)
   );

   ////////////////////////////////////////////////////////////
   // issue selection
   ////////////////////////////////////////////////////////////

   issue_select u_select (
      .clk_i            (clk_i),
      .rst_i            (rst_i),
      .fu_rdy_i         (fu_rdy_i),
      .slot_vld_i       (slot_vld),
      .slot_op_i        (slot_op),
      .slot_psrc1_i     (slot_psrc1),
      .slot_psrc2_i     (slot_psrc2),
      .slot_pdest_i     (slot_pdest),
      .slot_free_preg_i (slot_free_preg),
      .slot_src_rdy_i   (slot_src_rdy),
      .clr_mask_o       (clr_mask),
      .mul_vld_o,
      .mul_idx_o,
      .mul_psrc1_o,
      .mul_psrc2_o,
      .mul_pdest_o,
      .mul_free_preg_o,
      .alu1_vld_o,
      .alu1_idx_o,
      .alu1_psrc1_o,
      .alu1_psrc2_o,
      .alu1_pdest_o,
      .alu1_free_preg_o,
      .alu2_vld_o,
      .alu2_idx_o,
      .alu2_psrc1_o,
      .alu2_psrc2_o,
      .alu2_pdest_o,
      .alu2_free_preg_o,
      .adr_vld_o,
      .adr_idx_o,
      .adr_psrc1_o,
      .adr_psrc2_o,
      .adr_pdest_o,
      .adr_free_preg_o
   );

endmodule

// ==== logic/issue_select.sv ====
`timescale 1ns/1ps
`include "isq_defs.svh"

module issue_select (
   input  logic                  clk_i,
   input  logic                  rst_i,
   // one ready level per function unit
   input  logic [3:0]            fu_rdy_i,
   // slot state from the store and the ready table
   input  logic [`ISQ_DEPTH-1:0] slot_vld_i,
   input  isq_pkg::op_class_e    slot_op_i [`ISQ_DEPTH],
   input  isq_pkg::preg_t        slot_psrc1_i [`ISQ_DEPTH],
   input  isq_pkg::preg_t        slot_psrc2_i [`ISQ_DEPTH],
   input  isq_pkg::preg_t        slot_pdest_i [`ISQ_DEPTH],
   input  isq_pkg::free_preg_t   slot_free_preg_i [`ISQ_DEPTH],
   input  logic [`ISQ_DEPTH-1:0] slot_src_rdy_i,
   // slots leaving the queue this cycle
   output logic [`ISQ_DEPTH-1:0] clr_mask_o,
   // multiplier port
   output logic                  mul_vld_o,
   output isq_pkg::slot_idx_t    mul_idx_o,
   output isq_pkg::preg_t        mul_psrc1_o,
   output isq_pkg::preg_t        mul_psrc2_o,
   output isq_pkg::preg_t        mul_pdest_o,
   output isq_pkg::free_preg_t   mul_free_preg_o,
   // alu 1 port, also takes branches and jumps
   output logic                  alu1_vld_o,
   output isq_pkg::slot_idx_t    alu1_idx_o,
   output isq_pkg::preg_t        alu1_psrc1_o,
   output isq_pkg::preg_t        alu1_psrc2_o,
   output isq_pkg::preg_t        alu1_pdest_o,
   output isq_pkg::free_preg_t   alu1_free_preg_o,
   // alu 2 port
   output logic                  alu2_vld_o,
   output isq_pkg::slot_idx_t    alu2_idx_o,
   output isq_pkg::preg_t        alu2_psrc1_o,
   output isq_pkg::preg_t        alu2_psrc2_o,
   output isq_pkg::preg_t        alu2_pdest_o,
   output isq_pkg::free_preg_t   alu2_free_preg_o,
   // address adder port
   output logic                  adr_vld_o,
   output isq_pkg::slot_idx_t    adr_idx_o,
   output isq_pkg::preg_t        adr_psrc1_o,
   output isq_pkg::preg_t        adr_psrc2_o,
   output isq_pkg::preg_t        adr_pdest_o,
   output isq_pkg::free_preg_t   adr_free_preg_o
);

   import isq_pkg::*;

   localparam int FU_NUM = 4;

   // slot class fits the port, indexed by the fu bit position
   logic [`ISQ_DEPTH-1:0]  class_hit [FU_NUM];
   logic [`ISQ_DEPTH-1:0]  elig [FU_NUM];
   // lowest eligible slot per port
   logic [`ISQ_DEPTH-1:0]  pick_oh [FU_NUM];
   slot_idx_t              pick_idx [FU_NUM];
   logic [FU_NUM-1:0]      pick_vld;
   // registered issue packets
   logic [FU_NUM-1:0]      port_vld_q;
   slot_idx_t              port_idx_q [FU_NUM];
   preg_t                  port_psrc1_q [FU_NUM];
   preg_t                  port_psrc2_q [FU_NUM];
   preg_t                  port_pdest_q [FU_NUM];
   free_preg_t             port_free_preg_q [FU_NUM];

   ////////////////////////////////////////////////////////////
   // class to port routing
   ////////////////////////////////////////////////////////////

   // adds split by slot index, multiples of 3 go to alu 1
   // so alu 1 and alu 2 never see the same slot
   for (genvar s = 0; s < `ISQ_DEPTH; s++)
   begin : g_slot
      assign class_hit[`FU_MULT_BIT][s] = (slot_op_i[s] == OP_MULT);
      assign class_hit[`FU_ALU1_BIT][s] = (slot_op_i[s] == OP_BRJMP) ||
                                          ((slot_op_i[s] == OP_ADD) && (s % 3 == 0));
      assign class_hit[`FU_ALU2_BIT][s] = (slot_op_i[s] == OP_ADD) && (s % 3 != 0);
      assign class_hit[`FU_ADDR_BIT][s] = (slot_op_i[s] == OP_ADDR);
   end

   ////////////////////////////////////////////////////////////
   // eligibility and priority pick
   ////////////////////////////////////////////////////////////

   for (genvar p = 0; p < FU_NUM; p++)
   begin : g_port
      // waiting, sources ready, right class, unit not stalled
      assign elig[p] = class_hit[p] & slot_vld_i & slot_src_rdy_i & {`ISQ_DEPTH{fu_rdy_i[p]}};
      assign pick_vld[p] = |elig[p];

      // lowest index wins, top down scan keeps the last hit
      always_comb
      begin
         pick_idx[p] = '0;
         pick_oh[p]  = '0;
         for (int s = `ISQ_DEPTH-1; s >= 0; s--)
         begin
            if (elig[p][s])
            begin
               pick_idx[p]   = slot_idx_t'(s);
               pick_oh[p]    = '0;
               pick_oh[p][s] = 1'b1;
            end
         end
      end
   end

   // picks are disjoint, one slot goes to at most one port
   // cleared on the edge that loads the port register
   assign clr_mask_o = pick_oh[0] | pick_oh[1] | pick_oh[2] | pick_oh[3];

   ////////////////////////////////////////////////////////////
   // issue registers
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         port_vld_q <= '0;
      else
         port_vld_q <= pick_vld;
   end

   // packet in register read order: idx, sources, dest, free reg
   always_ff @(posedge clk_i)
   begin
      for (int p = 0; p < FU_NUM; p++)
      begin
         port_idx_q[p]       <= pick_idx[p];
         port_psrc1_q[p]     <= slot_psrc1_i[pick_idx[p]];
         port_psrc2_q[p]     <= slot_psrc2_i[pick_idx[p]];
         port_pdest_q[p]     <= slot_pdest_i[pick_idx[p]];
         port_free_preg_q[p] <= slot_free_preg_i[pick_idx[p]];
      end
   end

   // named port outputs
   assign mul_vld_o        = port_vld_q[`FU_MULT_BIT];
   assign mul_idx_o        = port_idx_q[`FU_MULT_BIT];
   assign mul_psrc1_o      = port_psrc1_q[`FU_MULT_BIT];
   assign mul_psrc2_o      = port_psrc2_q[`FU_MULT_BIT];
   assign mul_pdest_o      = port_pdest_q[`FU_MULT_BIT];
   assign mul_free_preg_o  = port_free_preg_q[`FU_MULT_BIT];

   assign alu1_vld_o       = port_vld_q[`FU_ALU1_BIT];
   assign alu1_idx_o       = port_idx_q[`FU_ALU1_BIT];
   assign alu1_psrc1_o     = port_psrc1_q[`FU_ALU1_BIT];
   assign alu1_psrc2_o     = port_psrc2_q[`FU_ALU1_BIT];
   assign alu1_pdest_o     = port_pdest_q[`FU_ALU1_BIT];
   assign alu1_free_preg_o = port_free_preg_q[`FU_ALU1_BIT];

   assign alu2_vld_o       = port_vld_q[`FU_ALU2_BIT];
   assign alu2_idx_o       = port_idx_q[`FU_ALU2_BIT];
   assign alu2_psrc1_o     = port_psrc1_q[`FU_ALU2_BIT];
   assign alu2_psrc2_o     = port_psrc2_q[`FU_ALU2_BIT];
   assign alu2_pdest_o     = port_pdest_q[`FU_ALU2_BIT];
   assign alu2_free_preg_o = port_free_preg_q[`FU_ALU2_BIT];

   assign adr_vld_o        = port_vld_q[`FU_ADDR_BIT];
   assign adr_idx_o        = port_idx_q[`FU_ADDR_BIT];
   assign adr_psrc1_o      = port_psrc1_q[`FU_ADDR_BIT];
   assign adr_psrc2_o      = port_psrc2_q[`FU_ADDR_BIT];
   assign adr_pdest_o      = port_pdest_q[`FU_ADDR_BIT];
   assign adr_free_preg_o  = port_free_preg_q[`FU_ADDR_BIT];

endmodule

// ==== logic/preg_ready_table.sv ====
`timescale 1ns/1ps
`include "isq_defs.svh"

module preg_ready_table (
   input  logic                  clk_i,
   input  logic                  rst_i,
   // destination of the instruction being dispatched
   input  logic                  disp_vld_i,
   input  isq_pkg::preg_t        disp_pdest_i,
   // result written back this cycle
   input  logic                  wb_vld_i,
   input  isq_pkg::preg_t        wb_preg_i,
   // sources of every slot
   input  isq_pkg::preg_t        slot_psrc1_i [`ISQ_DEPTH],
   input  isq_pkg::preg_t        slot_psrc2_i [`ISQ_DEPTH],
   // both sources available, per slot
   output logic [`ISQ_DEPTH-1:0] slot_src_rdy_o
);

   import isq_pkg::*;

   // one bit per physical register, set means value is in the file
   logic [`PREG_NUM-1:0] preg_rdy;

   ////////////////////////////////////////////////////////////
   // ready bit update
   ////////////////////////////////////////////////////////////

   // all registers hold architectural values after reset
   // dispatch is written last so it wins over a writeback
   // to the same register
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
         preg_rdy <= '1;
      else
      begin
         if (wb_vld_i)
            preg_rdy[wb_preg_i] <= 1'b1;
         // new producer, consumers must wait for its writeback
         if (disp_vld_i)
            preg_rdy[disp_pdest_i] <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // per slot lookup
   ////////////////////////////////////////////////////////////

   // live every cycle, so a writeback at an edge makes the
   // consumer eligible right after that edge
   always_comb
   begin
      for (int s = 0; s < `ISQ_DEPTH; s++)
      begin
         slot_src_rdy_o[s] = preg_rdy[slot_psrc1_i[s]] & preg_rdy[slot_psrc2_i[s]];
      end
   end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the issue queue testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f issue_queue.f --top-module tb_issue_queue -o sim_issue_queue

./obj_dir/sim_issue_queue > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
   exit 1
fi
grep -q "Simulation passed" sim.log

// ==== tb/issue_queue_sva.sv ====
`timescale 1ns/1ps
`include "isq_defs.svh"

module issue_queue_sva (
   input  logic                  clk_i,
   input  logic                  rst_i,
   input  logic [3:0]            fu_rdy_i,
   input  logic                  disp_full_o,
   input  logic                  mul_vld_o,
   input  isq_pkg::slot_idx_t    mul_idx_o,
   input  logic                  alu1_vld_o,
   input  isq_pkg::slot_idx_t    alu1_idx_o,
   input  logic                  alu2_vld_o,
   input  isq_pkg::slot_idx_t    alu2_idx_o,
   input  logic                  adr_vld_o,
   input  isq_pkg::slot_idx_t    adr_idx_o
);

   import isq_pkg::*;

   // failed assertions, read by the testbench for its verdict
   int fail_cnt = 0;
   // slots issued in this cycle over all ports
   logic [`ISQ_DEPTH-1:0] iss_mask;
   logic                  collide;

   always_comb
   begin
      iss_mask = '0;
      collide  = 1'b0;
      if (mul_vld_o)
         iss_mask[mul_idx_o] = 1'b1;
      if (alu1_vld_o)
      begin
         collide = collide | iss_mask[alu1_idx_o];
         iss_mask[alu1_idx_o] = 1'b1;
      end
      if (alu2_vld_o)
      begin
         collide = collide | iss_mask[alu2_idx_o];
         iss_mask[alu2_idx_o] = 1'b1;
      end
      if (adr_vld_o)
      begin
         collide = collide | iss_mask[adr_idx_o];
         iss_mask[adr_idx_o] = 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////
   // reset and back-pressure
   ////////////////////////////////////////////////////////////

   a_reset_quiet: assert property (@(posedge clk_i) rst_i |=>
      !(mul_vld_o || alu1_vld_o || alu2_vld_o || adr_vld_o || disp_full_o))
      else begin $error("port active after reset"); fail_cnt = fail_cnt + 1; end

   a_mul_stall: assert property (@(posedge clk_i) disable iff (rst_i)
      !fu_rdy_i[`FU_MULT_BIT] |=> !mul_vld_o)
      else begin $error("multiplier issued while stalled"); fail_cnt = fail_cnt + 1; end
   a_alu1_stall: assert property (@(posedge clk_i) disable iff (rst_i)
      !fu_rdy_i[`FU_ALU1_BIT] |=> !alu1_vld_o)
      else begin $error("alu 1 issued while stalled"); fail_cnt = fail_cnt + 1; end
   a_alu2_stall: assert property (@(posedge clk_i) disable iff (rst_i)
      !fu_rdy_i[`FU_ALU2_BIT] |=> !alu2_vld_o)
      else begin $error("alu 2 issued while stalled"); fail_cnt = fail_cnt + 1; end
   a_adr_stall: assert property (@(posedge clk_i) disable iff (rst_i)
      !fu_rdy_i[`FU_ADDR_BIT] |=> !adr_vld_o)
      else begin $error("address adder issued while stalled"); fail_cnt = fail_cnt + 1; end

   ////////////////////////////////////////////////////////////
   // routing and single issue
   ////////////////////////////////////////////////////////////

   // alu 2 never sees slots 0, 3 or 6
   a_alu2_split: assert property (@(posedge clk_i) disable iff (rst_i)
      alu2_vld_o |-> (int'(alu2_idx_o) % 3 != 0))
      else begin $error("alu 2 issued a multiple-of-3 slot"); fail_cnt = fail_cnt + 1; end

   a_no_collide: assert property (@(posedge clk_i) disable iff (rst_i) !collide)
      else begin $error("one slot issued on two ports"); fail_cnt = fail_cnt + 1; end

   // a freed slot needs two edges before it can issue again
   a_once: assert property (@(posedge clk_i) disable iff (rst_i)
      (iss_mask & $past(iss_mask)) == '0)
      else begin $error("slot issued twice in a row"); fail_cnt = fail_cnt + 1; end

endmodule

// ==== tb/tb_issue_queue.sv ====
`timescale 1ns/1ps
`include "isq_defs.svh"

module tb_issue_queue;

   import isq_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 5;
   // rough length of each test in cycles
   localparam int TEST_CYCLES  = 20 + 20 + 20 + 150;
   localparam int MARGIN       = 50;

   logic       clk_i = 1'b0;
   logic       rst_i = 1'b1;
   logic       disp_vld_i = 1'b0;
   op_class_e  disp_op_i = OP_ADD;
   preg_t      disp_psrc1_i = '0;
   preg_t      disp_psrc2_i = '0;
   preg_t      disp_pdest_i = '0;
   free_preg_t disp_free_preg_i = '0;
   logic       disp_full_o;
   logic       wb_vld_i = 1'b0;
   preg_t      wb_preg_i = '0;
   logic [3:0] fu_rdy_i = '0;

   // dut ports indexed by fu bit position
   logic       dut_vld [4];
   slot_idx_t  dut_idx [4];
   preg_t      dut_s1 [4];
   preg_t      dut_s2 [4];
   preg_t      dut_d [4];
   free_preg_t dut_f [4];

   // shadow slots, ready bits and expected port registers
   logic [`ISQ_DEPTH-1:0] sh_vld;
   op_class_e  sh_op [`ISQ_DEPTH];
   preg_t      sh_s1 [`ISQ_DEPTH];
   preg_t      sh_s2 [`ISQ_DEPTH];
   preg_t      sh_d [`ISQ_DEPTH];
   free_preg_t sh_f [`ISQ_DEPTH];
   logic [`PREG_NUM-1:0] sh_rdy;
   logic       exp_vld [4];
   slot_idx_t  exp_idx [4];
   preg_t      exp_s1 [4];
   preg_t      exp_s2 [4];
   preg_t      exp_d [4];
   free_preg_t exp_f [4];

   int errors = 0;
   int tests = 0;
   int disp_cnt = 0;
   int issued_cnt = 0;
   integer seed = 60033;

   issue_queue DUT (
      .clk_i, .rst_i, .disp_vld_i, .disp_op_i, .disp_psrc1_i, .disp_psrc2_i,
      .disp_pdest_i, .disp_free_preg_i, .disp_full_o, .wb_vld_i, .wb_preg_i, .fu_rdy_i,
      .mul_vld_o(dut_vld[0]), .mul_idx_o(dut_idx[0]), .mul_psrc1_o(dut_s1[0]),
      .mul_psrc2_o(dut_s2[0]), .mul_pdest_o(dut_d[0]), .mul_free_preg_o(dut_f[0]),
      .alu1_vld_o(dut_vld[1]), .alu1_idx_o(dut_idx[1]), .alu1_psrc1_o(dut_s1[1]),
      .alu1_psrc2_o(dut_s2[1]), .alu1_pdest_o(dut_d[1]), .alu1_free_preg_o(dut_f[1]),
      .alu2_vld_o(dut_vld[2]), .alu2_idx_o(dut_idx[2]), .alu2_psrc1_o(dut_s1[2]),
      .alu2_psrc2_o(dut_s2[2]), .alu2_pdest_o(dut_d[2]), .alu2_free_preg_o(dut_f[2]),
      .adr_vld_o(dut_vld[3]), .adr_idx_o(dut_idx[3]), .adr_psrc1_o(dut_s1[3]),
      .adr_psrc2_o(dut_s2[3]), .adr_pdest_o(dut_d[3]), .adr_free_preg_o(dut_f[3])
   );

   bind issue_queue issue_queue_sva u_sva (.*);

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   // port for a class in a given slot, adds split on multiples of 3
   function automatic int port_of(input op_class_e op, input int s);
      case (op)
         OP_MULT:  return `FU_MULT_BIT;
         OP_BRJMP: return `FU_ALU1_BIT;
         OP_ADD:   return (s % 3 == 0) ? `FU_ALU1_BIT : `FU_ALU2_BIT;
         default:  return `FU_ADDR_BIT;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////
   // shadow model
   ////////////////////////////////////////////////////////////

   always @(posedge clk_i)
   begin : shadow
      logic [`ISQ_DEPTH-1:0] clr;
      int fs;
      if (rst_i)
      begin
         sh_vld = '0;
         sh_rdy = '1;
         for (int p = 0; p < 4; p++)
            exp_vld[p] = 1'b0;
      end
      else
      begin
         clr = '0;
         // lowest eligible slot per port, from pre-edge state
         for (int p = 0; p < 4; p++)
         begin
            exp_vld[p] = 1'b0;
            for (int s = 0; s < `ISQ_DEPTH; s++)
            begin
               if (!exp_vld[p] && sh_vld[s] && sh_rdy[sh_s1[s]] && sh_rdy[sh_s2[s]]
                   && fu_rdy_i[p] && port_of(sh_op[s], s) == p)
               begin
                  exp_vld[p] = 1'b1;
                  exp_idx[p] = slot_idx_t'(s);
                  exp_s1[p]  = sh_s1[s];
                  exp_s2[p]  = sh_s2[s];
                  exp_d[p]   = sh_d[s];
                  exp_f[p]   = sh_f[s];
                  clr[s]     = 1'b1;
               end
            end
         end
         fs = -1;
         for (int s = `ISQ_DEPTH-1; s >= 0; s--)
            if (!sh_vld[s])
               fs = s;
         sh_vld = sh_vld & ~clr;
         if (disp_vld_i && fs >= 0)
         begin
            sh_vld[fs] = 1'b1;
            sh_op[fs]  = disp_op_i;
            sh_s1[fs]  = disp_psrc1_i;
            sh_s2[fs]  = disp_psrc2_i;
            sh_d[fs]   = disp_pdest_i;
            sh_f[fs]   = disp_free_preg_i;
            disp_cnt++;
         end
         // dispatch wins over writeback on one register
         if (wb_vld_i)
            sh_rdy[wb_preg_i] = 1'b1;
         if (disp_vld_i)
            sh_rdy[disp_pdest_i] = 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // checks at the falling edge
   ////////////////////////////////////////////////////////////

   task automatic mismatch(input int p, input string what);
      $display("MISMATCH at %0t: port %0d %s", $time, p, what);
      errors++;
   endtask

   always @(negedge clk_i)
   begin
      if (!rst_i)
      begin
         assert (disp_full_o === (&sh_vld)) else mismatch(-1, "full flag");
         for (int p = 0; p < 4; p++)
         begin
            assert (dut_vld[p] === exp_vld[p]) else mismatch(p, "valid");
            if (dut_vld[p] && exp_vld[p])
            begin
               assert (dut_idx[p] === exp_idx[p]) else mismatch(p, "slot index");
               assert (dut_s1[p] === exp_s1[p]) else mismatch(p, "psrc1");
               assert (dut_s2[p] === exp_s2[p]) else mismatch(p, "psrc2");
               assert (dut_d[p] === exp_d[p]) else mismatch(p, "pdest");
               assert (dut_f[p] === exp_f[p]) else mismatch(p, "free preg");
            end
            if (dut_vld[p] === 1'b1)
               issued_cnt++;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   task automatic drive(input logic dv, input op_class_e op, input preg_t s1, input preg_t s2,
                        input preg_t d, input logic wv, input preg_t wp);
      @(posedge clk_i);
      #2;
      // rename holds back while the queue is full
      disp_vld_i       = dv && !disp_full_o;
      disp_op_i        = op;
      disp_psrc1_i     = s1;
      disp_psrc2_i     = s2;
      disp_pdest_i     = d;
      disp_free_preg_i = {1'b1, d};
      wb_vld_i         = wv;
      wb_preg_i        = wp;
   endtask

   task automatic idle();
      drive(1'b0, OP_ADD, '0, '0, '0, 1'b0, '0);
   endtask

   // run until the queue and the port registers are empty
   task automatic drain();
      idle();
      while (sh_vld != '0 || exp_vld[0] || exp_vld[1] || exp_vld[2] || exp_vld[3])
         idle();
      idle();
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s finished, errors so far %0d", tests, name, errors);
   endtask

   initial
   begin
      // watchdog
      #((RESET_CYCLES + TEST_CYCLES + MARGIN) * CLK_PERIOD);
      $display("run timed out before all tests finished");
      $display("Simulation failed");
      $finish;
   end

   initial
   begin
      repeat (RESET_CYCLES) @(posedge clk_i);
      #2;
      rst_i = 1'b0;

      // fill with every unit blocked, sources 0..31 stay ready
      for (int i = 0; i < `ISQ_DEPTH; i++)
         drive(1'b1, op_class_e'(2'(i)), preg_t'(i), preg_t'(i + 1), preg_t'(32 + i),
               1'b0, '0);
      idle();
      idle();
      fu_rdy_i = 4'hf;
      drain();
      end_test("reset_and_full");

      // consumer of r40 waits for its writeback
      drive(1'b1, OP_MULT, 6'd1, 6'd2, 6'd40, 1'b0, '0);
      drive(1'b1, OP_ADD, 6'd40, 6'd3, 6'd41, 1'b0, '0);
      repeat (4) idle();
      drive(1'b0, OP_ADD, '0, '0, '0, 1'b1, 6'd40);
      drive(1'b0, OP_ADD, '0, '0, '0, 1'b1, 6'd41);
      drain();
      end_test("dependency");

      // several adds and multiplies held back, then released
      fu_rdy_i = 4'h0;
      for (int i = 0; i < 6; i++)
         drive(1'b1, (i == 4) ? OP_MULT : OP_ADD, preg_t'(i), preg_t'(i + 2),
               preg_t'(48 + i), 1'b0, '0);
      idle();
      fu_rdy_i = 4'hf;
      drain();
      end_test("priority_and_split");

      // random stream with random stalls and writebacks
      for (int i = 0; i < 60; i++)
      begin
         fu_rdy_i = 4'($random(seed));
         drive($random(seed) % 4 != 0, op_class_e'(2'($random(seed))),
               preg_t'($random(seed)), preg_t'($random(seed)), preg_t'($random(seed)),
               1'($random(seed)), preg_t'($random(seed)));
      end
      fu_rdy_i = 4'hf;
      for (int r = 0; r < `PREG_NUM; r++)
         drive(1'b0, OP_ADD, '0, '0, '0, 1'b1, preg_t'(r));
      drain();
      assert (issued_cnt == disp_cnt) else mismatch(-1, "issue count differs from dispatch count");
      end_test("random_backpressure");

      $display("tests %0d, testbench errors %0d, assertion failures %0d",
               tests, errors, DUT.u_sva.fail_cnt);
      if (errors == 0 && DUT.u_sva.fail_cnt == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
